// File: build.f
+incdir+src
src/mulPkg.sv
src/mulCtrlIf.sv
src/wbRegDecode.sv
src/shiftAddExec.sv
src/resultStage.sv
src/mulTop.sv
testbench/mulTb_sva.sv
testbench/mulTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the multiplier simulation with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mulTb -f build.f -o mulSim
./obj_dir/mulSim | tee sim.log

if grep -q "Regression failed" sim.log; then
    echo "Simulation reported errors, see sim.log"
    exit 1
fi

// File: testbench/mulTb.sv
// Multiplier directed testbench
`timescale 1ns/1ns
`include "mul_defs.svh"

module mulTb;

    localparam int WaitLimit = 100;

    // Directed operand pairs
    localparam logic [7:0] DirA [7] = '{8'h03, 8'hFD, 8'h07, 8'h80, 8'h80, 8'h00, 8'h7F};
    localparam logic [7:0] DirB [7] = '{8'h05, 8'h05, 8'hF7, 8'h80, 8'h7F, 8'hFF, 8'h7F};

    logic                  Clk;
    logic                  rstN;
    logic                  wbCyc;
    logic                  wbStb;
    logic                  wbWe;
    logic [`MUL_ADR_W-1:0] wbAdr;
    logic [7:0]            wbDatI;
    logic [7:0]            wbDatO;
    logic                  wbAck;
    logic                  busy;
    logic                  done;
    mulPkg::segPattern     hex0;
    mulPkg::segPattern     hex1;
    mulPkg::segPattern     hex2;
    mulPkg::segPattern     hex3;

    integer      seed;
    int          errCount;
    int          checkCount;
    int          testErrBase;
    int          busyFalls;
    logic        busyLast;
    logic [15:0] shownProd;

    mulTop u_dut (
        .Clk    (Clk),
        .rstN   (rstN),
        .wbCyc  (wbCyc),
        .wbStb  (wbStb),
        .wbWe   (wbWe),
        .wbAdr  (wbAdr),
        .wbDatI (wbDatI),
        .wbDatO (wbDatO),
        .wbAck  (wbAck),
        .busy   (busy),
        .done   (done),
        .hex0   (hex0),
        .hex1   (hex1),
        .hex2   (hex2),
        .hex3   (hex3)
    );

    always #4 Clk = ~Clk;

    // Count finished operations by the falling edge of busy
    always @(negedge Clk) begin
        if (busyLast && !busy) begin
            busyFalls = busyFalls + 1;
        end
        busyLast = busy;
    end

    // Common-anode digit table in active-low gfedcba order
    function automatic mulPkg::segPattern segFor(input logic [3:0] nibble);
        case (nibble)
            4'h0: return 7'h40;
            4'h1: return 7'h79;
            4'h2: return 7'h24;
            4'h3: return 7'h30;
            4'h4: return 7'h19;
            4'h5: return 7'h12;
            4'h6: return 7'h02;
            4'h7: return 7'h78;
            4'h8: return 7'h00;
            4'h9: return 7'h10;
            4'hA: return 7'h08;
            4'hB: return 7'h03;
            4'hC: return 7'h46;
            4'hD: return 7'h21;
            4'hE: return 7'h06;
            default: return 7'h0E;
        endcase
    endfunction

    function automatic logic signed [15:0] expectedProduct(input logic [7:0] a,
                                                          input logic [7:0] b);
        return 16'(int'($signed(a)) * int'($signed(b)));
    endfunction

    task automatic abortRun(input string what);
        $display("Timeout: %s", what);
        $display("Regression failed");
        $finish;
    endtask

    task automatic reportFailure(input string what);
        errCount++;
        $display("Error: %s", what);
    endtask

    task automatic checkByte(input string name, input logic [7:0] got, input logic [7:0] exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic checkProduct(input string name, input logic signed [15:0] got,
                                input logic signed [15:0] exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic checkSeg(input string name, input mulPkg::segPattern got,
                            input mulPkg::segPattern exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic checkDigits(input logic [15:0] prod);
        checkSeg("hex0", hex0, segFor(prod[3:0]));
        checkSeg("hex1", hex1, segFor(prod[7:4]));
        checkSeg("hex2", hex2, segFor(prod[11:8]));
        checkSeg("hex3", hex3, segFor(prod[15:12]));
    endtask

    task automatic waitAck(input string what);
        int n;
        n = 0;
        do begin
            @(negedge Clk);
            n++;
        end while (!wbAck && n < WaitLimit);
        if (!wbAck) begin
            abortRun(what);
        end
    endtask

    task automatic wbWrite(input logic [`MUL_ADR_W-1:0] adr, input logic [7:0] data);
        @(negedge Clk);
        wbCyc  = 1'b1;
        wbStb  = 1'b1;
        wbWe   = 1'b1;
        wbAdr  = adr;
        wbDatI = data;
        waitAck("no wbAck on a write");
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe  = 1'b0;
    endtask

    task automatic wbRead(input logic [`MUL_ADR_W-1:0] adr, output logic [7:0] data);
        @(negedge Clk);
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe  = 1'b0;
        wbAdr = adr;
        waitAck("no wbAck on a read");
        data  = wbDatO;
        wbCyc = 1'b0;
        wbStb = 1'b0;
    endtask

    task automatic waitDone();
        logic [7:0] status;
        int n;
        n = 0;
        status = 8'd0;
        while (!status[1] && n < WaitLimit) begin
            wbRead(`MUL_REG_STATUS, status);
            n++;
        end
        if (!status[1]) begin
            abortRun("done never set in STATUS");
        end
    endtask

    task automatic startOp(input logic [7:0] a, input logic [7:0] b);
        wbWrite(`MUL_REG_MCAND, a);
        wbWrite(`MUL_REG_MPLIER, b);
        wbWrite(`MUL_REG_CTRL, 8'h01);
    endtask

    task automatic readProduct(output logic [15:0] prod);
        logic [7:0] lo;
        logic [7:0] hi;
        wbRead(`MUL_REG_PRODL, lo);
        wbRead(`MUL_REG_PRODH, hi);
        prod = {hi, lo};
    endtask

    task automatic mulCheck(input logic [7:0] a, input logic [7:0] b);
        logic [15:0] prod;
        startOp(a, b);
        waitDone();
        if (!done) begin
            reportFailure("done output not set after completion");
        end
        readProduct(prod);
        checkProduct("product", prod, expectedProduct(a, b));
        checkDigits(expectedProduct(a, b));
        shownProd = expectedProduct(a, b);
    endtask

    task automatic reportTest(input string name);
        if (errCount == testErrBase) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errCount - testErrBase);
        end
        testErrBase = errCount;
    endtask

    task automatic testReset();
        logic [7:0] rd;
        wbRead(`MUL_REG_STATUS, rd);
        checkByte("STATUS", rd, 8'h00);
        wbRead(`MUL_REG_PRODL, rd);
        checkByte("PRODL", rd, 8'h00);
        wbRead(`MUL_REG_PRODH, rd);
        checkByte("PRODH", rd, 8'h00);
        checkDigits(16'h0000);
        wbWrite(`MUL_REG_MCAND, 8'hA5);
        wbWrite(`MUL_REG_MPLIER, 8'h3C);
        wbRead(`MUL_REG_MCAND, rd);
        checkByte("MCAND", rd, 8'hA5);
        wbRead(`MUL_REG_MPLIER, rd);
        checkByte("MPLIER", rd, 8'h3C);
        reportTest("reset and registers");
    endtask

    task automatic testDirected();
        for (int i = 0; i < 7; i++) begin
            mulCheck(DirA[i], DirB[i]);
        end
        reportTest("directed products");
    endtask

    task automatic testRandom();
        logic [7:0] a;
        logic [7:0] b;
        for (int i = 0; i < 20; i++) begin
            a = 8'($random(seed));
            b = 8'($random(seed));
            mulCheck(a, b);
        end
        reportTest("random products");
    endtask

    task automatic testBusyStart();
        logic [15:0] prod;
        int fallsBefore;
        fallsBefore = busyFalls;
        startOp(8'h0B, 8'hF3);
        @(negedge Clk);
        if (!busy) begin
            reportFailure("busy did not rise after start");
        end
        // New operands and a second start while the first runs
        wbWrite(`MUL_REG_MCAND, 8'h22);
        wbWrite(`MUL_REG_MPLIER, 8'h05);
        wbWrite(`MUL_REG_CTRL, 8'h01);
        waitDone();
        readProduct(prod);
        checkProduct("product", prod, expectedProduct(8'h0B, 8'hF3));
        // Long enough for a second operation to finish had one started
        repeat (30) @(negedge Clk);
        if (busyFalls != fallsBefore + 1) begin
            reportFailure("start while busy launched another operation");
        end
        wbWrite(`MUL_REG_CTRL, 8'h01);
        @(negedge Clk);
        if (done) begin
            reportFailure("done still set after a new start");
        end
        waitDone();
        readProduct(prod);
        checkProduct("product", prod, expectedProduct(8'h22, 8'h05));
        shownProd = expectedProduct(8'h22, 8'h05);
        reportTest("start while busy");
    endtask

    task automatic testDisplay();
        logic [15:0] prod;
        int n;
        n = 0;
        startOp(8'h9C, 8'h2D);
        @(negedge Clk);
        if (!busy) begin
            reportFailure("busy did not rise after start");
        end
        // Digits hold the previous product until completion
        while (busy && n < WaitLimit) begin
            checkDigits(shownProd);
            @(negedge Clk);
            n++;
        end
        if (busy) begin
            abortRun("busy never cleared");
        end
        waitDone();
        readProduct(prod);
        checkProduct("product", prod, expectedProduct(8'h9C, 8'h2D));
        checkDigits(expectedProduct(8'h9C, 8'h2D));
        reportTest("display");
    endtask

    initial begin
        Clk         = 1'b0;
        rstN        = 1'b0;
        wbCyc       = 1'b0;
        wbStb       = 1'b0;
        wbWe        = 1'b0;
        wbAdr       = '0;
        wbDatI      = 8'd0;
        seed        = 32'h9e41;
        errCount    = 0;
        checkCount  = 0;
        testErrBase = 0;
        busyFalls   = 0;
        busyLast    = 1'b0;
        shownProd   = 16'h0000;
        repeat (4) @(posedge Clk);
        @(negedge Clk);
        rstN = 1'b1;

        testReset();
        testDirected();
        testRandom();
        testBusyStart();
        testDisplay();

        $display("Checks run: %0d, errors: %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: testbench/mulTb_sva.sv
// Bus and engine assertions
`timescale 1ns/1ns

module mulTb_sva (
    input logic Clk,
    input logic rstN,
    input logic wbCyc,
    input logic wbStb,
    input logic wbAck,
    input logic productValid,
    input logic busy
);

    int busyCycles;

    // Cycles spent busy in the current operation
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            busyCycles <= 0;
        end else if (busy) begin
            busyCycles <= busyCycles + 1;
        end else begin
            busyCycles <= 0;
        end
    end

    ackOneCycle: assert property (@(posedge Clk) disable iff (!rstN) wbAck |=> !wbAck)
        else $error("wbAck held for more than one cycle");

    ackFollowsReq: assert property (@(posedge Clk) disable iff (!rstN)
        wbAck |-> $past(wbCyc && wbStb))
        else $error("wbAck without a preceding cyc and stb");

    validPulse: assert property (@(posedge Clk) disable iff (!rstN)
        productValid |=> !productValid)
        else $error("productValid wider than one cycle");

    // Worst case is eight add iterations
    busyBound: assert property (@(posedge Clk) disable iff (!rstN) busy |-> busyCycles < 26)
        else $error("busy held longer than 26 cycles");

endmodule

bind wbRegDecode mulTb_sva u_sva (
    .Clk          (Clk),
    .rstN         (rstN),
    .wbCyc        (wbCyc),
    .wbStb        (wbStb),
    .wbAck        (wbAck),
    .productValid (1'b0),
    .busy         (1'b0)
);

bind shiftAddExec mulTb_sva u_sva (
    .Clk          (Clk),
    .rstN         (rstN),
    .wbCyc        (1'b0),
    .wbStb        (1'b0),
    .wbAck        (1'b0),
    .productValid (productValid),
    .busy         (state != mulPkg::idle)
);

// File: src/mulTop.sv
// Wishbone signed multiplier top
`timescale 1ns/1ns
`include "mul_defs.svh"

module mulTop (
    input  logic                  Clk,
    input  logic                  rstN,
    input  logic                  wbCyc,
    input  logic                  wbStb,
    input  logic                  wbWe,
    input  logic [`MUL_ADR_W-1:0] wbAdr,
    input  logic [7:0]            wbDatI,
    output logic [7:0]            wbDatO,
    output logic                  wbAck,
    output logic                  busy,
    output logic                  done,
    output mulPkg::segPattern     hex0,
    output mulPkg::segPattern     hex1,
    output mulPkg::segPattern     hex2,
    output mulPkg::segPattern     hex3
);

    mulCtrlIf ctrlIf ();

    logic [`MUL_PROD_W-1:0] execProduct;
    logic                   productValid;
    logic [`MUL_PROD_W-1:0] heldProduct;

    wbRegDecode u_decode (
        .Clk     (Clk),
        .rstN    (rstN),
        .wbCyc   (wbCyc),
        .wbStb   (wbStb),
        .wbWe    (wbWe),
        .wbAdr   (wbAdr),
        .wbDatI  (wbDatI),
        .wbDatO  (wbDatO),
        .wbAck   (wbAck),
        .ctrl    (ctrlIf.regs),
        .product (heldProduct),
        .done    (done)
    );

    shiftAddExec u_exec (
        .Clk          (Clk),
        .rstN         (rstN),
        .ctrl         (ctrlIf.exec),
        .product      (execProduct),
        .productValid (productValid)
    );

    resultStage u_result (
        .Clk          (Clk),
        .rstN         (rstN),
        .start        (ctrlIf.start),
        .product      (execProduct),
        .productValid (productValid),
        .heldProduct  (heldProduct),
        .done         (done),
        .hex0         (hex0),
        .hex1         (hex1),
        .hex2         (hex2),
        .hex3         (hex3)
    );

    assign busy = ctrlIf.busy;

endmodule

// File: src/resultStage.sv
// Product hold and digit display
`timescale 1ns/1ns
`include "mul_defs.svh"

module resultStage (
    input  logic                   Clk,
    input  logic                   rstN,
    input  logic                   start,
    input  logic [`MUL_PROD_W-1:0] product,
    input  logic                   productValid,
    output logic [`MUL_PROD_W-1:0] heldProduct,
    output logic                   done,
    output mulPkg::segPattern      hex0,
    output mulPkg::segPattern      hex1,
    output mulPkg::segPattern      hex2,
    output mulPkg::segPattern      hex3
);

    // Last completed product, shown until the next one finishes
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            heldProduct <= '0;
        end else if (productValid) begin
            heldProduct <= product;
        end
    end

    // Sticky done, completion wins over a start in the same cycle
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            done <= 1'b0;
        end else if (productValid) begin
            done <= 1'b1;
        end else if (start) begin
            done <= 1'b0;
        end
    end

    // One digit per nibble, hex0 is the lowest
    assign hex0 = mulPkg::hexToSeg(heldProduct[3:0]);
    assign hex1 = mulPkg::hexToSeg(heldProduct[7:4]);
    assign hex2 = mulPkg::hexToSeg(heldProduct[11:8]);
    assign hex3 = mulPkg::hexToSeg(heldProduct[15:12]);

endmodule

// File: src/shiftAddExec.sv
// Shift-add signed multiply engine
`timescale 1ns/1ns
`include "mul_defs.svh"

module shiftAddExec (
    input  logic                   Clk,
    input  logic                   rstN,
    mulCtrlIf.exec                 ctrl,
    output logic [`MUL_PROD_W-1:0] product,
    output logic                   productValid
);

    localparam int CntW = $clog2(`MUL_OPND_W);

    mulPkg::execState state;
    mulPkg::execState nextState;

    // A accumulates, B holds the multiplier and receives the low product bits
    logic [`MUL_OPND_W-1:0] regA;
    logic [`MUL_OPND_W-1:0] regB;
    logic [`MUL_OPND_W-1:0] mcand;
    logic                   regX;
    logic [CntW-1:0]        iterCnt;
    logic                   lastIter;
    logic [`MUL_OPND_W:0]   extA;
    logic [`MUL_OPND_W:0]   extM;
    logic [`MUL_OPND_W:0]   sum;

    // Count wraps to zero on the eighth increment
    assign lastIter = (iterCnt == '0);

    // X sits above A as its sign bit
    assign extA = {regX, regA};
    assign extM = {mcand[`MUL_OPND_W-1], mcand};

    // The multiplier's sign bit has negative weight, so the last step subtracts
    assign sum = lastIter ? (extA - extM) : (extA + extM);

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            state <= mulPkg::idle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            mulPkg::idle: begin
                if (ctrl.start) begin
                    nextState = mulPkg::clearLoad;
                end
            end
            mulPkg::clearLoad: nextState = mulPkg::count;
            mulPkg::count: begin
                // Add only when the current multiplier bit is set
                nextState = regB[0] ? mulPkg::add : mulPkg::shift;
            end
            mulPkg::add: nextState = mulPkg::shift;
            mulPkg::shift: begin
                nextState = lastIter ? mulPkg::done : mulPkg::count;
            end
            mulPkg::done: nextState = mulPkg::idle;
            default: nextState = mulPkg::idle;
        endcase
    end

    // Iteration counter
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            iterCnt <= '0;
        end else if (state == mulPkg::clearLoad) begin
            iterCnt <= '0;
        end else if (state == mulPkg::count) begin
            iterCnt <= iterCnt + 1'b1;
        end
    end

    // Datapath
    always_ff @(posedge Clk) begin
        case (state)
            mulPkg::clearLoad: begin
                regA  <= '0;
                regX  <= 1'b0;
                regB  <= ctrl.multiplier;
                mcand <= ctrl.multiplicand;
            end
            mulPkg::add: begin
                regA <= sum[`MUL_OPND_W-1:0];
                regX <= sum[`MUL_OPND_W];
            end
            mulPkg::shift: begin
                // Arithmetic right shift of X:A:B, X keeps its value
                regA <= {regX, regA[`MUL_OPND_W-1:1]};
                regB <= {regA[0], regB[`MUL_OPND_W-1:1]};
            end
            default: ;
        endcase
    end

    assign ctrl.busy    = (state != mulPkg::idle);
    assign productValid = (state == mulPkg::done);
    assign product      = {regA, regB};

endmodule

// File: src/wbRegDecode.sv
// Wishbone register block
`timescale 1ns/1ns
`include "mul_defs.svh"

module wbRegDecode (
    input  logic                   Clk,
    input  logic                   rstN,
    input  logic                   wbCyc,
    input  logic                   wbStb,
    input  logic                   wbWe,
    input  logic [`MUL_ADR_W-1:0]  wbAdr,
    input  logic [7:0]             wbDatI,
    output logic [7:0]             wbDatO,
    output logic                   wbAck,
    mulCtrlIf.regs                 ctrl,
    input  logic [`MUL_PROD_W-1:0] product,
    input  logic                   done
);

    logic [`MUL_OPND_W-1:0] mcandReg;
    logic [`MUL_OPND_W-1:0] mplierReg;
    logic                   startPulse;
    logic                   accessNew;
    logic                   writeNew;
    logic [7:0]             readData;

    // A new access is one not yet acknowledged
    assign accessNew = wbCyc && wbStb && !wbAck;
    assign writeNew  = accessNew && wbWe;

    // Single-cycle ack, one edge after cyc and stb
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            wbAck <= 1'b0;
        end else begin
            wbAck <= accessNew;
        end
    end

    // Operand registers, written on the acking edge
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            mcandReg  <= '0;
            mplierReg <= '0;
        end else if (writeNew) begin
            case (wbAdr)
                `MUL_REG_MCAND:  mcandReg  <= wbDatI;
                `MUL_REG_MPLIER: mplierReg <= wbDatI;
                default: ;
            endcase
        end
    end

    // Start bit of CTRL is self-clearing
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            startPulse <= 1'b0;
        end else begin
            startPulse <= writeNew && (wbAdr == `MUL_REG_CTRL) && wbDatI[0];
        end
    end

    assign ctrl.multiplicand = mcandReg;
    assign ctrl.multiplier   = mplierReg;
    assign ctrl.start        = startPulse;

    // Read mux, address is held by the master through the ack cycle
    always_comb begin
        case (wbAdr)
            `MUL_REG_MCAND:  readData = mcandReg;
            `MUL_REG_MPLIER: readData = mplierReg;
            `MUL_REG_STATUS: readData = {6'd0, done, ctrl.busy};
            `MUL_REG_PRODL:  readData = product[7:0];
            `MUL_REG_PRODH:  readData = product[15:8];
            default:         readData = 8'd0;
        endcase
    end

    assign wbDatO = readData;

endmodule

// File: src/mulCtrlIf.sv
// Decode to execute control link
`timescale 1ns/1ns
`include "mul_defs.svh"

interface mulCtrlIf;

    // Operands held by the register block
    logic [`MUL_OPND_W-1:0] multiplicand;
    logic [`MUL_OPND_W-1:0] multiplier;

    // One-cycle request from a CTRL write
    logic start;

    // High while the engine works on an operation
    logic busy;

    modport regs (
        output multiplicand,
        output multiplier,
        output start,
        input  busy
    );

    modport exec (
        input  multiplicand,
        input  multiplier,
        input  start,
        output busy
    );

endinterface

// File: src/mulPkg.sv
// Multiplier types and helpers
package mulPkg;

    // Control sequence of the shift-add engine
    typedef enum logic [2:0] {
        idle,
        clearLoad,
        count,
        add,
        shift,
        done
    } execState;

    // One seven-segment digit, active low, bit order gfedcba
    typedef logic [6:0] segPattern;

    // Common-anode hex digit table
    function automatic segPattern hexToSeg(input logic [3:0] nibble);
        case (nibble)
            4'h0: return 7'h40;
            4'h1: return 7'h79;
            4'h2: return 7'h24;
            4'h3: return 7'h30;
            4'h4: return 7'h19;
            4'h5: return 7'h12;
            4'h6: return 7'h02;
            4'h7: return 7'h78;
            4'h8: return 7'h00;
            4'h9: return 7'h10;
            4'hA: return 7'h08;
            4'hB: return 7'h03;
            4'hC: return 7'h46;
            4'hD: return 7'h21;
            4'hE: return 7'h06;
            default: return 7'h0E;
        endcase
    endfunction

endpackage

// File: src/mul_defs.svh
// Multiplier shared constants
`ifndef MUL_DEFS_SVH
`define MUL_DEFS_SVH

// Operand and product widths
`define MUL_OPND_W 8
`define MUL_PROD_W 16

// Wishbone address width, data bus is 8 bits
`define MUL_ADR_W 3

// Register map
`define MUL_REG_MCAND  3'd0
`define MUL_REG_MPLIER 3'd1
`define MUL_REG_CTRL   3'd2
`define MUL_REG_STATUS 3'd3
`define MUL_REG_PRODL  3'd4
`define MUL_REG_PRODH  3'd5

`endif
